// File: rtl/host_cmd_decoder.sv
////////////////////////////////////////////////////////////////////////////
// The host waits for the acknowledge before each new word, so no stall.
// Porch and sync words of the video mode command are skipped.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module host_cmd_decoder (
	input  wire                           clk_sys,
	input  wire                           resetd,
	input  wire                           i_io_uio,
	input  wire                           i_io_clk,
	input  wire scaler_geom_pkg::io_word_t i_io_din,
	output logic                          o_io_ack,
	output logic                          o_cfg_wr,
	output scaler_geom_pkg::cfg_field_t   o_cfg_sel,
	output scaler_geom_pkg::io_word_t     o_cfg_data
);

	import scaler_geom_pkg::*;

	logic       io_sync;
	logic       strobe_rise;
	logic       has_cmd;
	logic [7:0] cmd;
	logic [3:0] word_cnt;
	logic       field_hit;
	cfg_field_t field_sel;

	// New word while the sync stage leads the acknowledge
	assign strobe_rise = io_sync & ~o_io_ack;

	////////////////////////////////////////////////////////////////////////////
	// Word index to register field
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		field_hit = 1'b0;
		field_sel = fld_width;
		case (cmd)
			CMD_VIDEO_MODE: begin
				// Only active width and height are kept
				if (word_cnt == 4'd0) begin
					field_hit = 1'b1;
					field_sel = fld_width;
				end else if (word_cnt == 4'd4) begin
					field_hit = 1'b1;
					field_sel = fld_height;
				end
			end
			CMD_VSET: begin
				field_hit = (word_cnt == 4'd0);
				field_sel = fld_vset;
			end
			CMD_HSET: begin
				field_hit = (word_cnt == 4'd0);
				field_sel = fld_hset_free;
			end
			CMD_AR_CUSTOM: begin
				case (word_cnt)
					4'd0: field_sel = fld_arc1x;
					4'd1: field_sel = fld_arc1y;
					4'd2: field_sel = fld_arc2x;
					default: field_sel = fld_arc2y;
				endcase
				field_hit = (word_cnt < 4'd4);
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Acknowledge and framing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_sync  <= 1'b0;
			o_io_ack <= 1'b0;
			has_cmd  <= 1'b0;
			cmd      <= '0;
			word_cnt <= '0;
			o_cfg_wr <= 1'b0;
		end else begin
			io_sync  <= i_io_clk;
			o_io_ack <= io_sync;
			o_cfg_wr <= 1'b0;
			if (!i_io_uio) begin
				has_cmd <= 1'b0;
				cmd     <= '0;
			end else if (strobe_rise) begin
				if (!has_cmd) begin
					has_cmd  <= 1'b1;
					cmd      <= i_io_din[7:0];
					word_cnt <= '0;
				end else begin
					// Saturate so long commands never wrap onto a field
					if (word_cnt != 4'hF)
						word_cnt <= word_cnt + 4'd1;
					o_cfg_wr <= field_hit;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (strobe_rise) begin
			o_cfg_sel  <= field_sel;
			o_cfg_data <= i_io_din;
		end
	end

endmodule

`default_nettype wire

// File: rtl/scaler_geom_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Geometry widths, register fields and command codes of the host port.
// Counts are 12 bits wide, so sizes above 4095 cannot be expressed.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package scaler_geom_pkg;

	// Pixel or line count
	typedef logic [11:0] pix_t;
	// Aspect value with bit 12 as the absolute size flag
	typedef logic [12:0] ar_t;
	typedef logic [15:0] io_word_t;

	typedef enum logic [2:0] {
		fld_width,
		fld_height,
		fld_vset,
		fld_hset_free,
		fld_arc1x,
		fld_arc1y,
		fld_arc2x,
		fld_arc2y
	} cfg_field_t;

	// Host command codes, low byte of the command word
	localparam logic [7:0] CMD_VIDEO_MODE = 8'h20;
	localparam logic [7:0] CMD_VSET       = 8'h27;
	localparam logic [7:0] CMD_HSET       = 8'h37;
	localparam logic [7:0] CMD_AR_CUSTOM  = 8'h3A;

	// 1080p until the host says otherwise
	localparam pix_t DEF_WIDTH  = 12'd1920;
	localparam pix_t DEF_HEIGHT = 12'd1080;

	localparam int MD_STEPS = 24;

	typedef enum logic [2:0] {
		st_choose, st_start_w, st_wait_w, st_start_h,
		st_wait_h, st_spare, st_clamp, st_bounds
	} calc_state_t;

endpackage

`default_nettype wire

// File: rtl/scaler_geom_top.sv
////////////////////////////////////////////////////////////////////////////
// Host port and core aspect inputs share clk_sys
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module scaler_geom_top (
	input  wire                            clk_sys,
	input  wire                            resetd,
	input  wire                            i_io_uio,
	input  wire                            i_io_clk,
	input  wire scaler_geom_pkg::io_word_t i_io_din,
	input  wire scaler_geom_pkg::ar_t      i_video_arx,
	input  wire scaler_geom_pkg::ar_t      i_video_ary,
	output wire                            o_io_ack,
	output wire scaler_geom_pkg::pix_t     o_out_width,
	output wire scaler_geom_pkg::pix_t     o_out_height,
	output wire scaler_geom_pkg::pix_t     o_hmin,
	output wire scaler_geom_pkg::pix_t     o_hmax,
	output wire scaler_geom_pkg::pix_t     o_vmin,
	output wire scaler_geom_pkg::pix_t     o_vmax
);

	import scaler_geom_pkg::*;

	// Decoder to register bank
	wire        cfg_wr;
	cfg_field_t cfg_sel;
	io_word_t   cfg_data;

	// Stored configuration
	pix_t width, height, vset, hset;
	wire  freescale;
	ar_t  arc1x, arc1y, arc2x, arc2y;

	host_cmd_decoder host_cmd_decoder_inst (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_io_uio(i_io_uio), .i_io_clk(i_io_clk), .i_io_din(i_io_din),
		.o_io_ack(o_io_ack),
		.o_cfg_wr(cfg_wr), .o_cfg_sel(cfg_sel), .o_cfg_data(cfg_data)
	);

	video_cfg_regs video_cfg_regs_inst (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_cfg_wr(cfg_wr), .i_cfg_sel(cfg_sel), .i_cfg_data(cfg_data),
		.o_width(width), .o_height(height), .o_vset(vset), .o_hset(hset),
		.o_freescale(freescale),
		.o_arc1x(arc1x), .o_arc1y(arc1y), .o_arc2x(arc2x), .o_arc2y(arc2y)
	);

	window_calc window_calc_inst (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_width(width), .i_height(height), .i_vset(vset), .i_hset(hset),
		.i_freescale(freescale),
		.i_arc1x(arc1x), .i_arc1y(arc1y), .i_arc2x(arc2x), .i_arc2y(arc2y),
		.i_video_arx(i_video_arx), .i_video_ary(i_video_ary),
		.o_out_width(o_out_width), .o_out_height(o_out_height),
		.o_hmin(o_hmin), .o_hmax(o_hmax), .o_vmin(o_vmin), .o_vmax(o_vmax)
	);

endmodule

`default_nettype wire

// File: rtl/umuldiv.sv
////////////////////////////////////////////////////////////////////////////
// Result keeps the low 12 bits of the quotient. A zero divisor gives ones.
// Start is ignored while busy.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module umuldiv (
	input  wire                        clk_sys,
	input  wire                        resetd,
	input  wire                        i_start,
	input  wire scaler_geom_pkg::pix_t i_mul1,
	input  wire scaler_geom_pkg::pix_t i_mul2,
	input  wire scaler_geom_pkg::pix_t i_div,
	output logic                       o_busy,
	output scaler_geom_pkg::pix_t      o_result
);

	import scaler_geom_pkg::*;

	localparam int PIX_W  = $bits(pix_t);
	localparam int PROD_W = 2 * PIX_W;
	localparam int STEP_W = $clog2(MD_STEPS + 1);

	logic [STEP_W-1:0] step;
	logic [PROD_W-1:0] quo;
	pix_t              rem;
	pix_t              div_r;
	logic [PIX_W:0]    rem_shift;
	logic              last_step;

	// Next partial remainder takes the top dividend bit
	assign rem_shift = {rem, quo[PROD_W-1]};
	assign last_step = (step == STEP_W'(MD_STEPS));

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			step   <= '0;
		end else if (!o_busy) begin
			o_busy <= i_start;
			step   <= '0;
		end else if (last_step) begin
			o_busy <= 1'b0;
		end else begin
			step <= step + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!o_busy) begin
			if (i_start) begin
				quo   <= i_mul1 * i_mul2;
				rem   <= '0;
				div_r <= i_div;
			end
		end else if (last_step) begin
			o_result <= (div_r == '0) ? '1 : quo[PIX_W-1:0];
		end else if (rem_shift >= {1'b0, div_r}) begin
			rem <= PIX_W'(rem_shift - {1'b0, div_r});
			quo <= {quo[PROD_W-2:0], 1'b1};
		end else begin
			rem <= rem_shift[PIX_W-1:0];
			quo <= {quo[PROD_W-2:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// File: rtl/video_cfg_regs.sv
////////////////////////////////////////////////////////////////////////////
// One field written per cycle, from the bits that field uses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module video_cfg_regs (
	input  wire                            clk_sys,
	input  wire                            resetd,
	input  wire                            i_cfg_wr,
	input  wire scaler_geom_pkg::cfg_field_t i_cfg_sel,
	input  wire scaler_geom_pkg::io_word_t i_cfg_data,
	output scaler_geom_pkg::pix_t          o_width,
	output scaler_geom_pkg::pix_t          o_height,
	output scaler_geom_pkg::pix_t          o_vset,
	output scaler_geom_pkg::pix_t          o_hset,
	output logic                           o_freescale,
	output scaler_geom_pkg::ar_t           o_arc1x,
	output scaler_geom_pkg::ar_t           o_arc1y,
	output scaler_geom_pkg::ar_t           o_arc2x,
	output scaler_geom_pkg::ar_t           o_arc2y
);

	import scaler_geom_pkg::*;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_width     <= DEF_WIDTH;
			o_height    <= DEF_HEIGHT;
			o_vset      <= '0;
			o_hset      <= '0;
			o_freescale <= 1'b0;
			o_arc1x     <= '0;
			o_arc1y     <= '0;
			o_arc2x     <= '0;
			o_arc2y     <= '0;
		end else if (i_cfg_wr) begin
			case (i_cfg_sel)
				fld_width:  o_width  <= i_cfg_data[11:0];
				fld_height: o_height <= i_cfg_data[11:0];
				fld_vset:   o_vset   <= i_cfg_data[11:0];
				fld_hset_free: begin
					// Bit 15 is free scale, bits 14:12 unused
					o_freescale <= i_cfg_data[15];
					o_hset      <= i_cfg_data[11:0];
				end
				fld_arc1x: o_arc1x <= i_cfg_data[12:0];
				fld_arc1y: o_arc1y <= i_cfg_data[12:0];
				fld_arc2x: o_arc2x <= i_cfg_data[12:0];
				fld_arc2y: o_arc2y <= i_cfg_data[12:0];
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/window_calc.sv
////////////////////////////////////////////////////////////////////////////
// Bounds follow a config change after at most two full FSM passes.
// No done flag is given.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module window_calc (
	input  wire                        clk_sys,
	input  wire                        resetd,
	input  wire scaler_geom_pkg::pix_t i_width,
	input  wire scaler_geom_pkg::pix_t i_height,
	input  wire scaler_geom_pkg::pix_t i_vset,
	input  wire scaler_geom_pkg::pix_t i_hset,
	input  wire                        i_freescale,
	input  wire scaler_geom_pkg::ar_t  i_arc1x,
	input  wire scaler_geom_pkg::ar_t  i_arc1y,
	input  wire scaler_geom_pkg::ar_t  i_arc2x,
	input  wire scaler_geom_pkg::ar_t  i_arc2y,
	input  wire scaler_geom_pkg::ar_t  i_video_arx,
	input  wire scaler_geom_pkg::ar_t  i_video_ary,
	output scaler_geom_pkg::pix_t      o_out_width,
	output scaler_geom_pkg::pix_t      o_out_height,
	output scaler_geom_pkg::pix_t      o_hmin,
	output scaler_geom_pkg::pix_t      o_hmax,
	output scaler_geom_pkg::pix_t      o_vmin,
	output scaler_geom_pkg::pix_t      o_vmax
);

	import scaler_geom_pkg::*;

	calc_state_t state;
	pix_t        ar_x, ar_y;
	logic        ar_abs;
	logic        fill_out;
	logic        md_start, md_busy;
	pix_t        md_mul1, md_mul2, md_div, md_res;
	pix_t        wcalc, hcalc, videow, videoh;
	pix_t        h_off, v_off;

	umuldiv umuldiv_inst (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	// Video fills the output when no ratio is usable
	assign fill_out = i_freescale || (ar_x == '0) || (ar_y == '0);
	assign h_off    = (i_width - videow) >> 1;
	assign v_off    = (i_height - videoh) >> 1;

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state        <= st_choose;
			md_start     <= 1'b0;
			o_out_width  <= '0;
			o_out_height <= '0;
			o_hmin       <= '0;
			o_hmax       <= '0;
			o_vmin       <= '0;
			o_vmax       <= '0;
		end else begin
			// Overrides count only when smaller than the mode
			o_out_height <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;
			o_out_width  <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
			md_start     <= 1'b0;
			case (state)
				st_choose:  state <= (fill_out || ar_abs) ? st_clamp : st_start_w;
				st_start_w: begin
					md_start <= 1'b1;
					state    <= st_wait_w;
				end
				st_wait_w:  if (!md_start && !md_busy) state <= st_start_h;
				st_start_h: begin
					md_start <= 1'b1;
					state    <= st_wait_h;
				end
				st_wait_h:  if (!md_start && !md_busy) state <= st_spare;
				st_spare:   state <= st_clamp;
				st_clamp:   state <= st_bounds;
				st_bounds: begin
					o_hmin <= h_off;
					o_hmax <= h_off + videow - 12'd1;
					o_vmin <= v_off;
					o_vmax <= v_off + videoh - 12'd1;
					state  <= st_choose;
				end
				default:    state <= st_choose;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Aspect select and size datapath
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		// ARY of zero means ARX picks a custom pair
		if (i_video_ary == '0) begin
			if (i_video_arx == 13'd1) begin
				ar_x   <= i_arc1x[11:0];
				ar_y   <= i_arc1y[11:0];
				ar_abs <= i_arc1x[12] | i_arc1y[12];
			end else if (i_video_arx == 13'd2) begin
				ar_x   <= i_arc2x[11:0];
				ar_y   <= i_arc2y[11:0];
				ar_abs <= i_arc2x[12] | i_arc2y[12];
			end else begin
				ar_x   <= '0;
				ar_y   <= '0;
				ar_abs <= 1'b0;
			end
		end else begin
			ar_x   <= i_video_arx[11:0];
			ar_y   <= i_video_ary[11:0];
			ar_abs <= i_video_arx[12] | i_video_ary[12];
		end

		case (state)
			st_choose: begin
				if (fill_out) begin
					wcalc <= o_out_width;
					hcalc <= o_out_height;
				end else if (ar_abs) begin
					wcalc <= ar_x;
					hcalc <= ar_y;
				end
			end
			st_start_w: begin
				md_mul1 <= o_out_height;
				md_mul2 <= ar_x;
				md_div  <= ar_y;
			end
			st_wait_w:  wcalc <= md_res;
			st_start_h: begin
				md_mul1 <= o_out_width;
				md_mul2 <= ar_y;
				md_div  <= ar_x;
			end
			st_wait_h:  hcalc <= md_res;
			st_clamp: begin
				videow <= (wcalc > o_out_width) ? o_out_width : wcalc;
				videoh <= (hcalc > o_out_height) ? o_out_height : hcalc;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module scaler_geom_tb -f scaler_geom.f \
	&& ./obj_dir/Vscaler_geom_tb | tee /dev/stderr | grep -qx "TEST RESULT: PASS" \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }

// File: scaler_geom.f
rtl/scaler_geom_pkg.sv
rtl/host_cmd_decoder.sv
rtl/video_cfg_regs.sv
rtl/umuldiv.sv
rtl/window_calc.sv
rtl/scaler_geom_top.sv
verification/scaler_geom_tb.sv

// File: verification/scaler_geom_tb.sv
////////////////////////////////////////////////////////////////////////////
// Outputs are compared only after the worst case settle time of two passes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module scaler_geom_tb;

	import scaler_geom_pkg::*;

	localparam int SETTLE_CYCLES  = 2 * (8 + 2 * (MD_STEPS + 2)) + 8;
	localparam int ACK_LIMIT      = 10;
	localparam int TIMEOUT_CYCLES = 12000;

	logic     clk_sys;
	logic     resetd;
	logic     i_io_uio;
	logic     i_io_clk;
	io_word_t i_io_din;
	ar_t      i_video_arx;
	ar_t      i_video_ary;
	wire      o_io_ack;
	pix_t     o_out_width, o_out_height, o_hmin, o_hmax, o_vmin, o_vmax;

	// Host side copy of the register bank
	pix_t        m_width, m_height, m_vset, m_hset;
	logic        m_free;
	ar_t         m_arc [4];
	pix_t        e_ow, e_oh, e_hmin, e_hmax, e_vmin, e_vmax;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          test_start_errs = 0;
	int          cycle_count = 0;
	logic [31:0] rng = 32'h55daf910;

	scaler_geom_top scaler_geom_top_inst (
		.clk_sys(clk_sys), .resetd(resetd),
		.i_io_uio(i_io_uio), .i_io_clk(i_io_clk), .i_io_din(i_io_din),
		.i_video_arx(i_video_arx), .i_video_ary(i_video_ary),
		.o_io_ack(o_io_ack),
		.o_out_width(o_out_width), .o_out_height(o_out_height),
		.o_hmin(o_hmin), .o_hmax(o_hmax), .o_vmin(o_vmin), .o_vmax(o_vmax)
	);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles without finishing", cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host port
	////////////////////////////////////////////////////////////////////////////

	task automatic send_word(input io_word_t word);
		int n;
		i_io_din = word;
		i_io_clk = 1'b1;
		n = 0;
		while (o_io_ack !== 1'b1 && n < ACK_LIMIT) begin
			step();
			n++;
		end
		checks++;
		if (o_io_ack !== 1'b1) begin
			$display("Acknowledge for word %h did not rise within %0d cycles",
				word, ACK_LIMIT);
			errors++;
		end
		i_io_clk = 1'b0;
		n = 0;
		while (o_io_ack !== 1'b0 && n < ACK_LIMIT) begin
			step();
			n++;
		end
		if (o_io_ack !== 1'b0) begin
			$display("Acknowledge for word %h did not fall within %0d cycles",
				word, ACK_LIMIT);
			errors++;
		end
	endtask

	task automatic open_cmd(input logic [7:0] code);
		i_io_uio = 1'b1;
		send_word({8'h00, code});
	endtask

	task automatic close_cmd();
		step();
		i_io_uio = 1'b0;
		step();
	endtask

	// Porch and sync words are small enough to show up as an override
	task automatic send_video_mode(input pix_t w, input pix_t h);
		open_cmd(CMD_VIDEO_MODE);
		send_word({4'h0, w});
		send_word(16'h0011);
		send_word(16'h0022);
		send_word(16'h0033);
		send_word({4'h0, h});
		send_word(16'h0044);
		send_word(16'h0055);
		send_word(16'h0066);
		close_cmd();
		m_width  = w;
		m_height = h;
	endtask

	task automatic send_vset(input pix_t v);
		open_cmd(CMD_VSET);
		send_word({4'h0, v});
		close_cmd();
		m_vset = v;
	endtask

	task automatic send_hset(input pix_t h, input logic free);
		open_cmd(CMD_HSET);
		send_word({free, 3'b000, h});
		close_cmd();
		m_hset = h;
		m_free = free;
	endtask

	task automatic send_custom_ar(input ar_t a1x, input ar_t a1y,
		input ar_t a2x, input ar_t a2y);
		open_cmd(CMD_AR_CUSTOM);
		send_word({3'b000, a1x});
		send_word({3'b000, a1y});
		send_word({3'b000, a2x});
		send_word({3'b000, a2y});
		close_cmd();
		m_arc[0] = a1x;
		m_arc[1] = a1y;
		m_arc[2] = a2x;
		m_arc[3] = a2y;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic compute_expected(input ar_t arx, input ar_t ary);
		pix_t ax, ay, vw, vh;
		logic abs_sz;
		e_oh = (m_vset != '0 && m_vset < m_height) ? m_vset : m_height;
		e_ow = (m_hset != '0 && m_hset < m_width) ? m_hset : m_width;
		ax = ary[11:0] == '0 ? '0 : arx[11:0];
		ay = ary[11:0];
		abs_sz = (ary == '0) ? 1'b0 : (arx[12] | ary[12]);
		if (ary == '0 && (arx == 13'd1 || arx == 13'd2)) begin
			ax = (arx == 13'd1) ? m_arc[0][11:0] : m_arc[2][11:0];
			ay = (arx == 13'd1) ? m_arc[1][11:0] : m_arc[3][11:0];
			abs_sz = (arx == 13'd1) ? (m_arc[0][12] | m_arc[1][12])
				: (m_arc[2][12] | m_arc[3][12]);
		end
		if (m_free || ax == '0 || ay == '0) begin
			vw = e_ow;
			vh = e_oh;
		end else if (abs_sz) begin
			vw = ax;
			vh = ay;
		end else begin
			// Quotient keeps its low 12 bits
			vw = 12'((int'(e_oh) * int'(ax)) / int'(ay));
			vh = 12'((int'(e_ow) * int'(ay)) / int'(ax));
		end
		vw = (vw > e_ow) ? e_ow : vw;
		vh = (vh > e_oh) ? e_oh : vh;
		e_hmin = (m_width - vw) >> 1;
		e_hmax = e_hmin + vw - 12'd1;
		e_vmin = (m_height - vh) >> 1;
		e_vmax = e_vmin + vh - 12'd1;
	endtask

	task automatic check_value(input string tag, input string name,
		input pix_t got, input pix_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL at %0t: %s %s is %0d, expected %0d",
				$time, tag, name, got, exp);
			errors++;
		end
	endtask

	task automatic apply_and_check(input ar_t arx, input ar_t ary, input string tag);
		i_video_arx = arx;
		i_video_ary = ary;
		repeat (SETTLE_CYCLES) step();
		compute_expected(arx, ary);
		check_value(tag, "o_out_width", o_out_width, e_ow);
		check_value(tag, "o_out_height", o_out_height, e_oh);
		check_value(tag, "o_hmin", o_hmin, e_hmin);
		check_value(tag, "o_hmax", o_hmax, e_hmax);
		check_value(tag, "o_vmin", o_vmin, e_vmin);
		check_value(tag, "o_vmax", o_vmax, e_vmax);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%s: %s", name, (errors == test_start_errs) ? "ok" : "failed");
		test_start_errs = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset();
		check_value("reset", "o_io_ack", {11'b0, o_io_ack}, 12'd0);
		apply_and_check('0, '0, "reset");
		check_value("reset", "o_hmax", o_hmax, 12'd1919);
		check_value("reset", "o_vmax", o_vmax, 12'd1079);
		end_test("test 1 reset defaults");
	endtask

	task automatic test_video_mode();
		send_video_mode(12'd1280, 12'd720);
		apply_and_check('0, '0, "mode");
		check_value("mode", "o_out_width", o_out_width, 12'd1280);
		check_value("mode", "o_vmax", o_vmax, 12'd719);
		end_test("test 2 video mode command");
	endtask

	task automatic test_aspect_4_3();
		send_video_mode(12'd1920, 12'd1080);
		apply_and_check(13'd4, 13'd3, "4:3");
		check_value("4:3", "o_hmin", o_hmin, 12'd240);
		check_value("4:3", "o_hmax", o_hmax, 12'd1679);
		check_value("4:3", "o_vmin", o_vmin, 12'd0);
		check_value("4:3", "o_vmax", o_vmax, 12'd1079);
		end_test("test 3 aspect 4:3");
	endtask

	task automatic test_random_aspect();
		ar_t arx, ary;
		for (int i = 0; i < 8; i++) begin
			rng = next_rand(rng);
			arx = (rng[7:0] == 8'd0) ? 13'd1 : {5'b0, rng[7:0]};
			rng = next_rand(rng);
			ary = (rng[7:0] == 8'd0) ? 13'd1 : {5'b0, rng[7:0]};
			apply_and_check(arx, ary, "random");
		end
		// Width clamps when wider than the output
		apply_and_check(13'd21, 13'd9, "21:9");
		end_test("test 4 random aspect");
	endtask

	task automatic test_overrides();
		send_vset(12'd900);
		send_hset(12'd1600, 1'b1);
		apply_and_check(13'd16, 13'd9, "override");
		check_value("override", "o_out_width", o_out_width, 12'd1600);
		check_value("override", "o_hmin", o_hmin, 12'd160);
		check_value("override", "o_vmin", o_vmin, 12'd90);
		// At or above the stored size counts as no override
		send_vset(12'd1080);
		send_hset(12'd2000, 1'b1);
		apply_and_check(13'd16, 13'd9, "ignored override");
		send_vset('0);
		send_hset('0, 1'b0);
		end_test("test 5 size overrides");
	endtask

	task automatic test_custom_aspect();
		send_custom_ar(13'd5, 13'd4, 13'h1000 | 13'd800, 13'h1000 | 13'd600);
		apply_and_check(13'd1, '0, "custom ratio");
		apply_and_check(13'd2, '0, "custom abs pair 2");
		send_custom_ar(13'h1000 | 13'd640, 13'h1000 | 13'd480, '0, '0);
		apply_and_check(13'd1, '0, "custom abs pair 1");
		end_test("test 6 custom aspect");
	endtask

	initial begin
		clk_sys     = 1'b0;
		resetd      = 1'b1;
		i_io_uio    = 1'b0;
		i_io_clk    = 1'b0;
		i_io_din    = '0;
		i_video_arx = '0;
		i_video_ary = '0;
		m_width     = DEF_WIDTH;
		m_height    = DEF_HEIGHT;
		m_vset      = '0;
		m_hset      = '0;
		m_free      = 1'b0;
		for (int i = 0; i < 4; i++)
			m_arc[i] = '0;
		repeat (5) @(posedge clk_sys);
		#2;
		resetd = 1'b0;
		test_reset();
		test_video_mode();
		test_aspect_4_3();
		test_random_aspect();
		test_overrides();
		test_custom_aspect();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
